// File: source/scurve_pkg.sv
`default_nettype none

package scurve_pkg;

    ////////////////////////////////////////
    // Scan data types
    ////////////////////////////////////////

    // Threshold DAC code
    typedef logic [9:0] dac_t;

    // Trigger count, also used for window length
    typedef logic [15:0] count_t;

    // One word on the result stream
    typedef logic [15:0] word_t;

    // Window mode, set high for trigger efficiency
    typedef enum logic {
        MODE_COUNT = 1'b0,
        MODE_TRIG  = 1'b1
    } mode_e;

    ////////////////////////////////////////
    // Stream word format
    ////////////////////////////////////////

    // Upper six bits of a header word, DAC code below
    localparam logic [5:0] HDR_TAG = 6'b101010;

    ////////////////////////////////////////
    // APB register map, byte offsets
    ////////////////////////////////////////

    localparam logic [3:0] REG_CTRL      = 4'h0;
    localparam logic [3:0] REG_DAC_RANGE = 4'h4;
    localparam logic [3:0] REG_WINDOW    = 4'h8;
    localparam logic [3:0] REG_STATUS    = 4'hC;

endpackage

`default_nettype wire

// File: source/scurve_window_if.sv
`timescale 1ns/100ps
`default_nettype none

interface scurve_window_if;

    // Zero all trigger counters, one cycle
    logic clear;
    // High while the counting window is open
    logic open;
    // Latch counts, cycle after open falls
    logic capture;
    // Code of the current step
    scurve_pkg::dac_t dac_code;
    // Packer still streaming this step
    logic drain_busy;

    modport ctrl (
        output clear, open, capture, dac_code,
        input  drain_busy
    );

    modport chan (
        input clear, open
    );

    modport drain (
        input  capture, dac_code,
        output drain_busy
    );

endinterface

`default_nettype wire

// File: source/scurve_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module scurve_apb_regs (
    input  logic                  Clk,
    input  logic                  reset_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [3:0]            paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  start_pulse,
    output scurve_pkg::mode_e     mode,
    output scurve_pkg::dac_t      start_dac,
    output scurve_pkg::dac_t      end_dac,
    output scurve_pkg::count_t    window_len,
    input  logic                  busy,
    input  logic                  done
);

    logic access;
    logic wr_en;
    logic addr_hit;

    // Access phase of a transfer
    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    // Only the four words of the map respond
    assign addr_hit = (paddr == scurve_pkg::REG_CTRL)      ||
                      (paddr == scurve_pkg::REG_DAC_RANGE) ||
                      (paddr == scurve_pkg::REG_WINDOW)    ||
                      (paddr == scurve_pkg::REG_STATUS);

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access && !addr_hit;

    ////////////////////////////////////////
    // Configuration and start
    ////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            mode        <= scurve_pkg::MODE_COUNT;
            start_dac   <= '0;
            end_dac     <= '0;
            window_len  <= '0;
            start_pulse <= 1'b0;
        end else begin
            // Start bit while idle, pulse follows the access phase
            start_pulse <= wr_en && (paddr == scurve_pkg::REG_CTRL) && pwdata[0] && !busy;
            if (wr_en) begin
                case (paddr)
                    scurve_pkg::REG_CTRL: mode <= scurve_pkg::mode_e'(pwdata[1]);
                    scurve_pkg::REG_DAC_RANGE: begin
                        start_dac <= pwdata[9:0];
                        end_dac   <= pwdata[25:16];
                    end
                    scurve_pkg::REG_WINDOW: window_len <= pwdata[15:0];
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////

    always_comb begin
        case (paddr)
            // Start reads back as zero
            scurve_pkg::REG_CTRL:      prdata = {30'd0, mode, 1'b0};
            scurve_pkg::REG_DAC_RANGE: prdata = {6'd0, end_dac, 6'd0, start_dac};
            scurve_pkg::REG_WINDOW:    prdata = {16'd0, window_len};
            scurve_pkg::REG_STATUS:    prdata = {30'd0, done, busy};
            default:                   prdata = '0;
        endcase
    end

    // Error response only inside an access phase
    a_slverr_phase: assert property (@(posedge Clk) disable iff (!reset_n)
        pslverr |-> psel && penable);

endmodule

`default_nettype wire

// File: source/scurve_scan_control.sv
`timescale 1ns/100ps
`default_nettype none

module scurve_scan_control #(
    parameter int TICK_DIV = 8
) (
    input  logic                  Clk,
    input  logic                  reset_n,
    input  logic                  start_pulse,
    input  scurve_pkg::mode_e     mode,
    input  scurve_pkg::dac_t      start_dac,
    input  scurve_pkg::dac_t      end_dac,
    input  scurve_pkg::count_t    window_len,
    input  logic                  config_done,
    input  logic                  ext_strobe,
    output logic                  sc_param_load,
    output logic                  force_ext_raz,
    output scurve_pkg::dac_t      dac_out,
    output logic                  busy,
    output logic                  done,
    scurve_window_if.ctrl         win
);

    localparam int TW = $clog2(TICK_DIV + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_WAIT_CFG,
        ST_CLEAR,
        ST_WINDOW,
        ST_CAPTURE,
        ST_WAIT_DRAIN,
        ST_NEXT
    } state_t;

    state_t             state;
    state_t             state_nx;
    scurve_pkg::dac_t   code;
    logic [TW-1:0]      tick_cnt;
    scurve_pkg::count_t win_cnt;
    logic [1:0]         strobe_sync;
    logic               strobe_d;
    logic               strobe_rise;
    logic               tick_end;
    logic               win_last;
    logic               window_end;
    logic               last_code;

    // Injection strobe edge after the synchronizer
    assign strobe_rise = strobe_sync[1] && !strobe_d;
    assign tick_end    = (tick_cnt == TW'(TICK_DIV - 1));
    // Current tick or strobe is the final one
    assign win_last    = (win_cnt + 16'd1) >= window_len;
    assign window_end  = win_last &&
                         ((mode == scurve_pkg::MODE_TRIG) ? strobe_rise : tick_end);
    assign last_code   = (code >= end_dac);

    ////////////////////////////////////////
    // Step sequencer
    ////////////////////////////////////////

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE:       if (start_pulse) state_nx = ST_LOAD;
            ST_LOAD:       state_nx = ST_WAIT_CFG;
            // Chip latency varies per load
            ST_WAIT_CFG:   if (config_done) state_nx = ST_CLEAR;
            ST_CLEAR:      state_nx = ST_WINDOW;
            ST_WINDOW:     if (window_end) state_nx = ST_CAPTURE;
            ST_CAPTURE:    state_nx = ST_WAIT_DRAIN;
            // Stream stalls hold the scan here
            ST_WAIT_DRAIN: if (!win.drain_busy) state_nx = ST_NEXT;
            ST_NEXT:       state_nx = last_code ? ST_IDLE : ST_LOAD;
            default:       state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= ST_IDLE;
            code        <= '0;
            done        <= 1'b0;
            tick_cnt    <= '0;
            win_cnt     <= '0;
            strobe_sync <= '0;
            strobe_d    <= 1'b0;
        end else begin
            state       <= state_nx;
            strobe_sync <= {strobe_sync[0], ext_strobe};
            strobe_d    <= strobe_sync[1];
            if (state == ST_IDLE && start_pulse) begin
                code <= start_dac;
                done <= 1'b0;
            end
            // Advance the code or finish the scan
            if (state == ST_NEXT) begin
                if (last_code) begin
                    done <= 1'b1;
                end else begin
                    code <= code + 10'd1;
                end
            end
            // Window timing, strobes or divided ticks
            if (state == ST_CLEAR) begin
                tick_cnt <= '0;
                win_cnt  <= '0;
            end else if (state == ST_WINDOW) begin
                if (mode == scurve_pkg::MODE_TRIG) begin
                    if (strobe_rise) begin
                        win_cnt <= win_cnt + 16'd1;
                    end
                end else if (tick_end) begin
                    tick_cnt <= '0;
                    win_cnt  <= win_cnt + 16'd1;
                end else begin
                    tick_cnt <= tick_cnt + TW'(1);
                end
            end
        end
    end

    // Decoded outputs
    assign busy          = (state != ST_IDLE);
    assign sc_param_load = (state == ST_LOAD);
    assign dac_out       = code;
    assign force_ext_raz = (state != ST_WINDOW);
    assign win.clear     = (state == ST_CLEAR);
    assign win.open      = (state == ST_WINDOW);
    assign win.capture   = (state == ST_CAPTURE);
    assign win.dac_code  = code;

    a_load_closed: assert property (@(posedge Clk) disable iff (!reset_n)
        !(win.open && sc_param_load));

    // Counts latched right after the window closes
    a_capture_after_open: assert property (@(posedge Clk) disable iff (!reset_n)
        $fell(win.open) |-> win.capture);

endmodule

`default_nettype wire

// File: source/trigger_counter.sv
`timescale 1ns/100ps
`default_nettype none

module trigger_counter (
    input  logic                Clk,
    input  logic                reset_n,
    input  logic                trigger_b,
    output scurve_pkg::count_t  count,
    scurve_window_if.chan       win
);

    logic [1:0] trig_sync;
    logic       trig_d;
    logic       trig_fall;

    // Asynchronous pin, idles high
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            trig_sync <= 2'b11;
            trig_d    <= 1'b1;
        end else begin
            trig_sync <= {trig_sync[0], trigger_b};
            trig_d    <= trig_sync[1];
        end
    end

    // Active-low trigger, count the falling edge
    assign trig_fall = trig_d && !trig_sync[1];

    ////////////////////////////////////////
    // Saturating count
    ////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (win.clear) begin
            count <= '0;
        end else if (win.open && trig_fall && (count != 16'hFFFF)) begin
            count <= count + 16'd1;
        end
    end

    a_count_monotonic: assert property (@(posedge Clk) disable iff (!reset_n)
        !$past(win.clear) |-> count >= $past(count));

endmodule

`default_nettype wire

// File: source/scurve_result_packer.sv
`timescale 1ns/100ps
`default_nettype none

module scurve_result_packer #(
    parameter int N_TRIG = 3
) (
    input  logic                Clk,
    input  logic                reset_n,
    input  scurve_pkg::count_t  counts [N_TRIG],
    output logic                result_valid,
    output scurve_pkg::word_t   result_data,
    input  logic                result_ready,
    scurve_window_if.drain      win
);

    localparam int IW = $clog2(N_TRIG + 1);

    // Header in slot 0, counts in trigger order after it
    scurve_pkg::word_t words [N_TRIG + 1];
    logic [IW-1:0]     idx;
    logic              xfer;
    logic              last_word;

    assign xfer      = result_valid && result_ready;
    assign last_word = (idx == IW'(N_TRIG));

    ////////////////////////////////////////
    // Holding array
    ////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (win.capture) begin
            words[0] <= {scurve_pkg::HDR_TAG, win.dac_code};
            for (int i = 0; i < N_TRIG; i++) begin
                words[i + 1] <= counts[i];
            end
        end
    end

    ////////////////////////////////////////
    // Stream sequencing
    ////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            result_valid <= 1'b0;
            idx          <= '0;
        end else if (win.capture) begin
            // Header valid the cycle after capture
            result_valid <= 1'b1;
            idx          <= '0;
        end else if (xfer) begin
            if (last_word) begin
                result_valid <= 1'b0;
            end else begin
                idx <= idx + IW'(1);
            end
        end
    end

    // Data comes straight from registers, so it holds under stall
    assign result_data = words[idx];

    // Covers the capture cycle too
    assign win.drain_busy = win.capture || result_valid;

    a_data_stable: assert property (@(posedge Clk) disable iff (!reset_n)
        result_valid && !result_ready |=> result_valid && $stable(result_data));

    // Controller must not capture while a step is still streaming
    a_no_overrun: assert property (@(posedge Clk) disable iff (!reset_n)
        win.capture |-> !result_valid);

endmodule

`default_nettype wire

// File: source/scurve_test_top.sv
`timescale 1ns/100ps
`default_nettype none

module scurve_test_top #(
    parameter int N_TRIG   = 3,
    parameter int TICK_DIV = 8
) (
    input  logic                Clk,
    input  logic                reset_n,
    // APB slave
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [3:0]          paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    // Chip slow control and discriminators
    output scurve_pkg::dac_t    dac_out,
    output logic                sc_param_load,
    input  logic                config_done,
    output logic                force_ext_raz,
    input  logic                ext_strobe,
    input  logic [N_TRIG-1:0]   trigger_b,
    // Result stream
    output logic                result_valid,
    output scurve_pkg::word_t   result_data,
    input  logic                result_ready,
    output logic                scan_done
);

    logic               start_pulse;
    scurve_pkg::mode_e  mode;
    scurve_pkg::dac_t   start_dac;
    scurve_pkg::dac_t   end_dac;
    scurve_pkg::count_t window_len;
    logic               busy;
    logic               done;
    scurve_pkg::count_t counts [N_TRIG];

    scurve_window_if u_win ();

    scurve_apb_regs u_regs (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .start_pulse (start_pulse),
        .mode        (mode),
        .start_dac   (start_dac),
        .end_dac     (end_dac),
        .window_len  (window_len),
        .busy        (busy),
        .done        (done)
    );

    scurve_scan_control #(
        .TICK_DIV (TICK_DIV)
    ) u_ctrl (
        .Clk           (Clk),
        .reset_n       (reset_n),
        .start_pulse   (start_pulse),
        .mode          (mode),
        .start_dac     (start_dac),
        .end_dac       (end_dac),
        .window_len    (window_len),
        .config_done   (config_done),
        .ext_strobe    (ext_strobe),
        .sc_param_load (sc_param_load),
        .force_ext_raz (force_ext_raz),
        .dac_out       (dac_out),
        .busy          (busy),
        .done          (done),
        .win           (u_win.ctrl)
    );

    // One counter per discriminator output
    for (genvar g = 0; g < N_TRIG; g++) begin : g_trig
        trigger_counter u_cnt (
            .Clk       (Clk),
            .reset_n   (reset_n),
            .trigger_b (trigger_b[g]),
            .count     (counts[g]),
            .win       (u_win.chan)
        );
    end

    scurve_result_packer #(
        .N_TRIG (N_TRIG)
    ) u_pack (
        .Clk          (Clk),
        .reset_n      (reset_n),
        .counts       (counts),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_ready (result_ready),
        .win          (u_win.drain)
    );

    assign scan_done = done;

endmodule

`default_nettype wire

// File: tests/tb_scurve_test.sv
`timescale 1ns/100ps
`default_nettype none

module tb_scurve_test;

    localparam int N_TRIG   = 3;
    localparam int TICK_DIV = 8;
    localparam logic [31:0] SEED = 32'hb547;

    // Worst case per step: config wait, trigger-mode window, stalled drain
    localparam int N_STEPS     = 3 + 2 + 4 + 1;
    localparam int STEP_MAX    = 8 + 80 + 64 + 8;
    localparam int CYCLE_LIMIT = N_STEPS * STEP_MAX + 600;

    logic                     Clk = 1'b0;
    logic                     reset_n;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [3:0]               paddr;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;
    scurve_pkg::dac_t         dac_out;
    logic                     sc_param_load;
    logic                     config_done = 1'b0;
    logic                     force_ext_raz;
    logic                     ext_strobe = 1'b0;
    logic [N_TRIG-1:0]        trigger_b = '1;
    logic                     result_valid;
    scurve_pkg::word_t        result_data;
    logic                     result_ready = 1'b1;
    logic                     scan_done;

    // Register shadows and scan expectations
    logic [31:0]              exp_range = '0;
    scurve_pkg::count_t       exp_window = '0;
    // Status bits expected on a read, busy in bit 0 and done in bit 1
    logic [1:0]               exp_status = 2'b00;
    logic                     mode_trig = 1'b0;
    logic                     bp_en = 1'b0;
    int                       scan_id = 0;
    scurve_pkg::dac_t         scan_start = '0;
    int                       exp_words = 0;
    int                       start_writes = 0;
    scurve_pkg::count_t       exp_cnt [N_TRIG];
    int                       strobes_given = 0;

    // Stream and step monitor state
    int                       seen_scan_id = 0;
    scurve_pkg::dac_t         load_code = '0;
    scurve_pkg::dac_t         exp_load;
    int                       words_seen = 0;
    logic [1:0]               word_idx = '0;
    int                       low_len = 0;
    scurve_pkg::word_t        data_q = '0;
    logic                     done_q = 1'b0;
    int                       writes_at_done = 0;

    logic [31:0]              rng_trig = SEED;
    logic [31:0]              rng_chip = SEED;
    logic [31:0]              rng_ready = SEED;
    int                       errors = 0;
    int                       errors_mark = 0;
    int                       tests_run = 0;
    int                       cycles = 0;

    logic                     acc;
    logic                     rd_acc;
    logic                     mapped;
    logic                     xfer;

    scurve_test_top #(
        .N_TRIG   (N_TRIG),
        .TICK_DIV (TICK_DIV)
    ) u_dut (
        .Clk           (Clk),
        .reset_n       (reset_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .dac_out       (dac_out),
        .sc_param_load (sc_param_load),
        .config_done   (config_done),
        .force_ext_raz (force_ext_raz),
        .ext_strobe    (ext_strobe),
        .trigger_b     (trigger_b),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .result_ready  (result_ready),
        .scan_done     (scan_done)
    );

    always #5 Clk = ~Clk;

    assign acc      = psel && penable;
    assign rd_acc   = acc && !pwrite;
    assign mapped   = paddr inside {scurve_pkg::REG_CTRL, scurve_pkg::REG_DAC_RANGE,
                                    scurve_pkg::REG_WINDOW, scurve_pkg::REG_STATUS};
    assign xfer     = result_valid && result_ready;
    // First load of a scan takes the start code, later loads step by one
    assign exp_load = (scan_id != seen_scan_id) ? scan_start : load_code + 10'd1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic log_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endtask

    ////////////////////////////////////////
    // APB master
    ////////////////////////////////////////

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        @(negedge Clk);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge Clk);
        penable = 1'b1;
        @(negedge Clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        // Shadow copy of what the map says reads back
        if (addr == scurve_pkg::REG_DAC_RANGE) exp_range = data & 32'h03FF_03FF;
        if (addr == scurve_pkg::REG_WINDOW) exp_window = data[15:0];
        if (addr == scurve_pkg::REG_CTRL && data[0]) start_writes++;
    endtask

    // Read data is checked by the assertions below
    task automatic read_reg(input logic [3:0] addr);
        @(negedge Clk);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge Clk);
        penable = 1'b1;
        @(negedge Clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic start_scan(input scurve_pkg::dac_t first, input scurve_pkg::dac_t last,
                              input logic [15:0] win_len, input logic trig_mode);
        write_reg(scurve_pkg::REG_DAC_RANGE, {6'd0, last, 6'd0, first});
        write_reg(scurve_pkg::REG_WINDOW, {16'd0, win_len});
        mode_trig  = trig_mode;
        scan_start = first;
        exp_words  = (int'(last) - int'(first) + 1) * (N_TRIG + 1);
        scan_id++;
        write_reg(scurve_pkg::REG_CTRL, {30'd0, trig_mode, 1'b1});
        // Old done clears one cycle after the start pulse
        @(negedge Clk);
        exp_status = 2'b01;
    endtask

    task automatic wait_scan_done;
        while (scan_done !== 1'b1) @(negedge Clk);
        repeat (2) @(negedge Clk);
        exp_status = 2'b10;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name, (errors == errors_mark) ? "ok" : "failed");
        errors_mark = errors;
    endtask

    ////////////////////////////////////////
    // Chip and stream models
    ////////////////////////////////////////

    // Config confirm after a random delay
    always begin : chip_model
        @(negedge Clk);
        if (sc_param_load === 1'b1) begin
            rng_chip = xorshift(rng_chip);
            repeat (1 + int'(rng_chip % 32'd6)) @(negedge Clk);
            config_done = 1'b1;
            @(negedge Clk);
            config_done = 1'b0;
        end
    end

    always @(negedge Clk) begin
        rng_ready    = xorshift(rng_ready);
        result_ready = bp_en ? rng_ready[7] : 1'b1;
    end

    // Pulses per window, then strobes in trigger mode
    always begin : window_stim
        @(negedge Clk);
        while (force_ext_raz !== 1'b0) @(negedge Clk);
        strobes_given = 0;
        for (int c = 0; c < N_TRIG; c++) begin
            rng_trig   = xorshift(rng_trig);
            exp_cnt[c] = 16'(rng_trig % 32'd6);
        end
        repeat (4) @(negedge Clk);
        for (int i = 0; i < 5; i++) begin
            for (int c = 0; c < N_TRIG; c++) begin
                if (i < int'(exp_cnt[c])) trigger_b[c] = 1'b0;
            end
            repeat (2) @(negedge Clk);
            trigger_b = '1;
            repeat (4) @(negedge Clk);
        end
        if (mode_trig) begin
            for (int s = 0; s < int'(exp_window); s++) begin
                ext_strobe = 1'b1;
                strobes_given++;
                repeat (3) @(negedge Clk);
                ext_strobe = 1'b0;
                repeat (7) @(negedge Clk);
            end
        end
        while (force_ext_raz !== 1'b1) @(negedge Clk);
    end

    always @(posedge Clk) begin
        data_q <= result_data;
        done_q <= scan_done;
        if (scan_done && !done_q) writes_at_done <= start_writes;
        if (sc_param_load) begin
            low_len <= 0;
        end else if (!force_ext_raz) begin
            low_len <= low_len + 1;
        end
        if (sc_param_load) begin
            load_code    <= dac_out;
            seen_scan_id <= scan_id;
            if (scan_id != seen_scan_id) words_seen <= 0;
        end else if (xfer) begin
            words_seen <= words_seen + 1;
            word_idx   <= (word_idx == 2'(N_TRIG)) ? 2'd0 : word_idx + 2'd1;
        end
    end

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_mapped_ok: assert property (@(posedge Clk) disable iff (!reset_n)
        acc && mapped |-> !pslverr && pready)
        else note_failure("mapped APB access gave an error or wait state");
    a_unmapped_err: assert property (@(posedge Clk) disable iff (!reset_n)
        acc && !mapped |-> pslverr)
        else note_failure("unmapped APB access gave no pslverr");
    a_unmapped_data: assert property (@(posedge Clk) disable iff (!reset_n)
        rd_acc && !mapped |-> prdata == 32'd0)
        else log_mismatch("prdata", 32'd0, $sampled(prdata));
    a_rd_range: assert property (@(posedge Clk) disable iff (!reset_n)
        rd_acc && paddr == scurve_pkg::REG_DAC_RANGE |-> prdata == exp_range)
        else log_mismatch("prdata", exp_range, $sampled(prdata));
    a_rd_window: assert property (@(posedge Clk) disable iff (!reset_n)
        rd_acc && paddr == scurve_pkg::REG_WINDOW |-> prdata == {16'd0, exp_window})
        else log_mismatch("prdata", {16'd0, exp_window}, $sampled(prdata));
    a_rd_status: assert property (@(posedge Clk) disable iff (!reset_n)
        rd_acc && paddr == scurve_pkg::REG_STATUS |-> prdata == {30'd0, exp_status})
        else log_mismatch("prdata", {30'd0, exp_status}, $sampled(prdata));

    // Code order and the header against the preceding load
    a_load_code: assert property (@(posedge Clk) disable iff (!reset_n)
        sc_param_load |-> dac_out == exp_load)
        else log_mismatch("dac_out", 32'(exp_load), 32'($sampled(dac_out)));
    a_header: assert property (@(posedge Clk) disable iff (!reset_n)
        xfer && word_idx == 2'd0 |-> result_data == {scurve_pkg::HDR_TAG, load_code})
        else log_mismatch("result_data", 32'({scurve_pkg::HDR_TAG, $sampled(load_code)}),
                          32'($sampled(result_data)));
    a_count: assert property (@(posedge Clk) disable iff (!reset_n)
        xfer && word_idx != 2'd0 |-> result_data == exp_cnt[word_idx - 2'd1])
        else log_mismatch("result_data", 32'(exp_cnt[$sampled(word_idx) - 2'd1]),
                          32'($sampled(result_data)));

    a_win_len: assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(force_ext_raz) && !mode_trig |-> low_len == int'(exp_window) * TICK_DIV)
        else log_mismatch("force_ext_raz low cycles", int'(exp_window) * TICK_DIV,
                          $sampled(low_len));
    a_strobes: assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(force_ext_raz) && mode_trig |-> strobes_given >= int'(exp_window))
        else note_failure("window closed before all strobes were given");

    a_stall: assert property (@(posedge Clk) disable iff (!reset_n)
        result_valid && !result_ready |=> result_valid && $stable(result_data))
        else log_mismatch("result_data", 32'($sampled(data_q)), 32'($sampled(result_data)));
    a_load_after_drain: assert property (@(posedge Clk) disable iff (!reset_n)
        sc_param_load |-> !result_valid)
        else note_failure("next code loaded before the previous step drained");
    a_word_total: assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(scan_done) |-> words_seen == exp_words)
        else log_mismatch("word count", exp_words, $sampled(words_seen));
    a_done_hold: assert property (@(posedge Clk) disable iff (!reset_n)
        $fell(scan_done) |-> start_writes != writes_at_done)
        else note_failure("scan_done fell without a start command");

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        reset_n = 1'b0;
        repeat (2) @(negedge Clk);
        reset_n = 1'b1;

        write_reg(scurve_pkg::REG_DAC_RANGE, {6'd0, 10'd7, 6'd0, 10'd5});
        write_reg(scurve_pkg::REG_WINDOW, 32'd5);
        read_reg(scurve_pkg::REG_DAC_RANGE);
        read_reg(scurve_pkg::REG_WINDOW);
        read_reg(4'h2);
        read_reg(scurve_pkg::REG_STATUS);
        finish_test("register access");

        // Status read lands while the first step runs
        start_scan(10'd5, 10'd7, 16'd5, 1'b0);
        read_reg(scurve_pkg::REG_STATUS);
        wait_scan_done();
        read_reg(scurve_pkg::REG_STATUS);
        finish_test("count mode scan");

        start_scan(10'd20, 10'd21, 16'd3, 1'b1);
        wait_scan_done();
        finish_test("trigger mode scan");

        // Random ready, second start mid-scan
        bp_en = 1'b1;
        start_scan(10'd100, 10'd103, 16'd5, 1'b0);
        repeat (60) @(negedge Clk);
        write_reg(scurve_pkg::REG_CTRL, 32'h1);
        wait_scan_done();
        bp_en = 1'b0;
        finish_test("back-pressure and start while busy");

        repeat (20) @(negedge Clk);
        start_scan(10'd9, 10'd9, 16'd5, 1'b0);
        wait_scan_done();
        finish_test("done hold and restart");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
source/scurve_pkg.sv
source/scurve_window_if.sv
source/scurve_apb_regs.sv
source/scurve_scan_control.sv
source/trigger_counter.sv
source/scurve_result_packer.sv
source/scurve_test_top.sv
tests/tb_scurve_test.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module tb_scurve_test \
    > build.log 2>&1 &&
./obj_dir/Vtb_scurve_test > sim.log 2>&1 &&
! grep -q "ERRORS FOUND" sim.log &&
echo "simulation passed, see sim.log" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
